// File: ntm_cfg.svh
// Width settings for the vector power unit
// Data word, exponent word and vector length counter

`ifndef NTM_CFG_SVH
`define NTM_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Base and result word, results wrap modulo 2**16
`define NTM_DATA_WIDTH 16

// Exponent word
`define NTM_EXP_WIDTH 8

//////////////////////////////////////////////////////////////////////
// Control widths
//////////////////////////////////////////////////////////////////////

// Vector length input, up to 255 elements
`define NTM_SIZE_WIDTH 8

`endif

// File: ntm_pkg.sv
// State encodings shared by the power unit controllers
// Multiplier, scalar exponentiator and vector sequencer FSMs

`default_nettype none

package ntm_pkg;

  // Shift-add multiplier
  typedef enum logic {
    MULT_IDLE,
    MULT_RUN
  } mult_state_t;

  // Square-and-multiply scan
  typedef enum logic [1:0] {
    EXP_IDLE,
    EXP_CHECK,
    EXP_MULT,
    EXP_SQUARE
  } exp_state_t;

  // Vector element sequencing, three steps
  typedef enum logic [1:0] {
    VEC_STARTER,
    VEC_INPUT,
    VEC_ENDER
  } vec_state_t;

endpackage

`default_nettype wire

// File: ntm_scalar_multiplier.sv
// Sequential shift-add multiplier
// One partial product per cycle, product truncated to the data word

`default_nettype none

`include "ntm_cfg.svh"

module ntm_scalar_multiplier import ntm_pkg::*; (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire                        START,
  input  wire [`NTM_DATA_WIDTH-1:0]  A,
  input  wire [`NTM_DATA_WIDTH-1:0]  B,
  output logic                       READY,
  output logic [`NTM_DATA_WIDTH-1:0] DATA_OUT
);

  // Counter must reach DATA_WIDTH itself for the final cycle
  localparam int CNT_W = $clog2(`NTM_DATA_WIDTH + 1);

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  mult_state_t                state;
  logic [CNT_W-1:0]           bit_cnt;

  // Shifted multiplicand, upper bits drop out of the word
  logic [`NTM_DATA_WIDTH-1:0] mcand;
  // Multiplier, consumed from the lowest bit
  logic [`NTM_DATA_WIDTH-1:0] mplier;
  logic [`NTM_DATA_WIDTH-1:0] acc;

  //////////////////////////////////////////////////////////////////////
  // Control and datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= MULT_IDLE;
      bit_cnt  <= '0;
      READY    <= 1'b0;
      DATA_OUT <= '0;
    end else begin
      // Single-cycle strobe
      READY <= 1'b0;
      case (state)
        MULT_IDLE: begin
          if (START) begin
            mcand   <= A;
            mplier  <= B;
            acc     <= '0;
            bit_cnt <= '0;
            state   <= MULT_RUN;
          end
        end
        MULT_RUN: begin
          if (bit_cnt == CNT_W'(`NTM_DATA_WIDTH)) begin
            // Final cycle, all partial products summed
            DATA_OUT <= acc;
            READY    <= 1'b1;
            state    <= MULT_IDLE;
          end else begin
            // Add partial product when the current bit is set
            if (mplier[0]) begin
              acc <= acc + mcand;
            end
            mcand   <= mcand << 1;
            mplier  <= mplier >> 1;
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= MULT_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: ntm_scalar_exponentiator.sv
// Scalar power unit, A to the B modulo 2**DATA_WIDTH
// Square-and-multiply over the exponent bits, one shared multiplier

`default_nettype none

`include "ntm_cfg.svh"

module ntm_scalar_exponentiator import ntm_pkg::*; (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire                        START,
  input  wire [`NTM_DATA_WIDTH-1:0]  DATA_A_IN,
  input  wire [`NTM_EXP_WIDTH-1:0]   DATA_B_IN,
  output logic                       READY,
  output logic [`NTM_DATA_WIDTH-1:0] DATA_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  exp_state_t                 state;

  // Running product, base power and remaining exponent bits
  logic [`NTM_DATA_WIDTH-1:0] result_reg;
  logic [`NTM_DATA_WIDTH-1:0] base_reg;
  logic [`NTM_EXP_WIDTH-1:0]  exp_reg;

  // Shared multiplier
  logic                       mult_start;
  logic                       mult_ready;
  logic [`NTM_DATA_WIDTH-1:0] mult_a;
  logic [`NTM_DATA_WIDTH-1:0] mult_out;

  // Set when bits above the current one are still nonzero
  logic                       bits_remain;

  assign bits_remain = (exp_reg[`NTM_EXP_WIDTH-1:1] != '0);

  // MULT takes result times base, SQUARE takes base times base
  assign mult_a = (state == EXP_MULT) ? result_reg : base_reg;

  //////////////////////////////////////////////////////////////////////
  // Scan FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= EXP_IDLE;
      mult_start <= 1'b0;
      READY      <= 1'b0;
      DATA_OUT   <= '0;
    end else begin
      // Strobes default low
      mult_start <= 1'b0;
      READY      <= 1'b0;
      case (state)
        EXP_IDLE: begin
          if (START) begin
            result_reg <= `NTM_DATA_WIDTH'(1);
            base_reg   <= DATA_A_IN;
            exp_reg    <= DATA_B_IN;
            state      <= EXP_CHECK;
          end
        end
        EXP_CHECK: begin
          if (exp_reg == '0) begin
            // Nothing left to scan
            DATA_OUT <= result_reg;
            READY    <= 1'b1;
            state    <= EXP_IDLE;
          end else if (exp_reg[0]) begin
            mult_start <= 1'b1;
            state      <= EXP_MULT;
          end else begin
            // Bit clear, higher bits still set
            mult_start <= 1'b1;
            state      <= EXP_SQUARE;
          end
        end
        EXP_MULT: begin
          if (mult_ready) begin
            result_reg <= mult_out;
            if (bits_remain) begin
              mult_start <= 1'b1;
              state      <= EXP_SQUARE;
            end else begin
              // Top bit done, skip the useless square
              exp_reg <= exp_reg >> 1;
              state   <= EXP_CHECK;
            end
          end
        end
        EXP_SQUARE: begin
          if (mult_ready) begin
            base_reg <= mult_out;
            exp_reg  <= exp_reg >> 1;
            state    <= EXP_CHECK;
          end
        end
        default: state <= EXP_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////////////////////////

  ntm_scalar_multiplier multiplier_i (
    .CLK      (CLK),
    .RST      (RST),
    .START    (mult_start),
    .A        (mult_a),
    .B        (base_reg),
    .READY    (mult_ready),
    .DATA_OUT (mult_out)
  );

endmodule

`default_nettype wire

// File: ntm_vector_exponentiator.sv
// Vector power unit, top level
// Collects operand pairs, runs the scalar unit per element,
// forwards results and flags the end of the vector

`default_nettype none

`include "ntm_cfg.svh"

module ntm_vector_exponentiator import ntm_pkg::*; (
  input  wire                        CLK,
  input  wire                        RST,
  input  wire                        START,
  output logic                       READY,
  input  wire                        DATA_A_IN_ENABLE,
  input  wire                        DATA_B_IN_ENABLE,
  output logic                       DATA_OUT_ENABLE,
  input  wire [`NTM_SIZE_WIDTH-1:0]  SIZE_IN,
  input  wire [`NTM_DATA_WIDTH-1:0]  DATA_A_IN,
  input  wire [`NTM_EXP_WIDTH-1:0]   DATA_B_IN,
  output logic [`NTM_DATA_WIDTH-1:0] DATA_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  vec_state_t                 state;
  logic [`NTM_SIZE_WIDTH-1:0] size_reg;
  logic [`NTM_SIZE_WIDTH-1:0] index_loop;
  logic                       last_element;

  // Operand held flags
  logic                       a_held;
  logic                       b_held;

  // Scalar unit
  logic                       start_scalar;
  logic                       ready_scalar;
  logic [`NTM_DATA_WIDTH-1:0] data_a_scalar;
  logic [`NTM_EXP_WIDTH-1:0]  data_b_scalar;
  logic [`NTM_DATA_WIDTH-1:0] data_out_scalar;

  assign last_element = (index_loop == size_reg - 1'b1);

  //////////////////////////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= VEC_STARTER;
      size_reg        <= '0;
      index_loop      <= '0;
      a_held          <= 1'b0;
      b_held          <= 1'b0;
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // All strobes last one cycle
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      case (state)
        VEC_STARTER: begin
          if (START) begin
            size_reg   <= SIZE_IN;
            index_loop <= '0;
            a_held     <= 1'b0;
            b_held     <= 1'b0;
            // Empty vector completes at once
            if (SIZE_IN == '0) begin
              READY <= 1'b1;
            end else begin
              state <= VEC_INPUT;
            end
          end
        end
        VEC_INPUT: begin
          if (a_held && b_held) begin
            start_scalar <= 1'b1;
            a_held       <= 1'b0;
            b_held       <= 1'b0;
            state        <= VEC_ENDER;
          end else begin
            // Strobes in any order, a repeat overwrites
            if (DATA_A_IN_ENABLE) begin
              data_a_scalar <= DATA_A_IN;
              a_held        <= 1'b1;
            end
            if (DATA_B_IN_ENABLE) begin
              data_b_scalar <= DATA_B_IN;
              b_held        <= 1'b1;
            end
          end
        end
        VEC_ENDER: begin
          if (DATA_OUT_ENABLE) begin
            // Result went out last cycle, READY marks the final one
            index_loop <= index_loop + 1'b1;
            state      <= READY ? VEC_STARTER : VEC_INPUT;
          end else if (ready_scalar) begin
            DATA_OUT        <= data_out_scalar;
            DATA_OUT_ENABLE <= 1'b1;
            READY           <= last_element;
          end
        end
        default: state <= VEC_STARTER;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scalar exponentiator
  //////////////////////////////////////////////////////////////////////

  ntm_scalar_exponentiator scalar_exponentiator_i (
    .CLK       (CLK),
    .RST       (RST),
    .START     (start_scalar),
    .DATA_A_IN (data_a_scalar),
    .DATA_B_IN (data_b_scalar),
    .READY     (ready_scalar),
    .DATA_OUT  (data_out_scalar)
  );

endmodule

`default_nettype wire

// File: ntm_exponentiator_checker.sv
// Protocol checker for the vector power unit, bound into the top level
// Output strobe spacing, scalar start pulse, completion rule and reset

`default_nettype none

`include "ntm_cfg.svh"

module ntm_exponentiator_checker (
  input wire                       CLK,
  input wire                       RST,
  input wire                       start,
  input wire [`NTM_SIZE_WIDTH-1:0] size_in,
  input wire                       ready,
  input wire                       data_out_enable,
  input wire                       start_scalar
);

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////////////////////////
  // Strobe rules
  //////////////////////////////////////////////////////////////////////

  // Result and completion strobes never stretch over two cycles
  assert property (@(posedge CLK) disable iff (RST)
    (data_out_enable || ready) |=> !(data_out_enable || ready))
    else $error("Output strobe high in two consecutive cycles");

  // Scalar start is a one-cycle pulse
  assert property (@(posedge CLK) disable iff (RST)
    start_scalar |=> !start_scalar)
    else $error("Scalar start held longer than one cycle");

  // Completion only with the last result, or right after an empty vector
  assert property (@(posedge CLK) disable iff (RST)
    ready |-> (data_out_enable || ($past(start) && ($past(size_in) == '0))))
    else $error("Completion without a result or an empty vector start");

  // Quiet outputs while reset is held
  assert property (@(posedge CLK)
    RST |-> (!ready && !data_out_enable))
    else $error("Output strobe high during reset");

endmodule

`default_nettype wire

// File: tb_ntm_vector_exponentiator.sv
// Testbench for the vector power unit
// Directed and random vectors, reference power model, result monitor,
// completion checks, stray strobes and watchdog

`default_nettype none

`include "ntm_cfg.svh"

module tb_ntm_vector_exponentiator;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DW = `NTM_DATA_WIDTH;
  localparam int EW = `NTM_EXP_WIDTH;
  localparam int SW = `NTM_SIZE_WIDTH;

  // Totals over all tests, also sizing the watchdog
  localparam int NUM_ELEMS       = 4 + 12 + 6 + 5 + 3;
  localparam int NUM_VECTORS     = 6;
  localparam int CYCLES_PER_ELEM = 500;
  localparam int RST_CYCLES      = 10;

  logic          CLK;
  logic          RST;
  logic          start;
  logic [SW-1:0] size_in;
  logic          data_a_in_enable;
  logic          data_b_in_enable;
  logic [DW-1:0] data_a_in;
  logic [EW-1:0] data_b_in;
  logic          ready;
  logic          data_out_enable;
  logic [DW-1:0] data_out;

  // Expected results and vector lengths, in issue order
  logic [DW-1:0] exp_q[$];
  int            size_q[$];
  logic [DW-1:0] expected_value;
  integer        seed = 32'h9d18;
  int            value_errors = 0;
  int            protocol_errors = 0;
  int            ready_count = 0;
  int            result_count = 0;
  int            cur_size = -1;
  int            vec_results = 0;

  ntm_vector_exponentiator dut_i (
    .CLK              (CLK),
    .RST              (RST),
    .START            (start),
    .READY            (ready),
    .DATA_A_IN_ENABLE (data_a_in_enable),
    .DATA_B_IN_ENABLE (data_b_in_enable),
    .DATA_OUT_ENABLE  (data_out_enable),
    .SIZE_IN          (size_in),
    .DATA_A_IN        (data_a_in),
    .DATA_B_IN        (data_b_in),
    .DATA_OUT         (data_out)
  );

  bind ntm_vector_exponentiator ntm_exponentiator_checker checker_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (START),
    .size_in         (SIZE_IN),
    .ready           (READY),
    .data_out_enable (DATA_OUT_ENABLE),
    .start_scalar    (start_scalar)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Repeated multiplication, wraps modulo 2**DW
  function automatic logic [DW-1:0] ref_power(input logic [DW-1:0] base,
                                              input logic [EW-1:0] power);
    logic [DW-1:0] acc;
    acc = DW'(1);
    for (int i = 0; i < int'(power); i++) begin
      acc = acc * base;
    end
    return acc;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Clock and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  initial begin
    repeat (RST_CYCLES + (NUM_ELEMS + NUM_VECTORS) * CYCLES_PER_ELEM) @(posedge CLK);
    $display("Watchdog expired at %0t, the DUT stopped producing results", $time);
    $display("*** TEST FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks, all driving on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic start_vector(input int len);
    @(negedge CLK);
    size_q.push_back(len);
    start   = 1'b1;
    size_in = SW'(len);
    @(negedge CLK);
    start   = 1'b0;
    size_in = '0;
  endtask

  // Order 0 sends A first, 1 sends B first, 2 sends both together
  task automatic send_pair(input logic [DW-1:0] a, input logic [EW-1:0] b,
                           input int order, input int gap);
    @(negedge CLK);
    exp_q.push_back(ref_power(a, b));
    data_a_in = a;
    data_b_in = b;
    data_a_in_enable = (order != 1);
    data_b_in_enable = (order != 0);
    @(negedge CLK);
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
    if (order < 2) begin
      // Idle gap before the second operand
      repeat (gap) @(negedge CLK);
      data_a_in_enable = (order == 1);
      data_b_in_enable = (order == 0);
      @(negedge CLK);
      data_a_in_enable = 1'b0;
      data_b_in_enable = 1'b0;
    end
  endtask

  // Junk operand strobes while the DUT does not accept them
  task automatic send_stray();
    @(negedge CLK);
    data_a_in = DW'($random(seed));
    data_b_in = EW'($random(seed));
    data_a_in_enable = 1'b1;
    data_b_in_enable = 1'b1;
    @(negedge CLK);
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
  endtask

  task automatic wait_result();
    do begin
      @(negedge CLK);
    end while (!data_out_enable);
  endtask

  // Empty vector READY is already up when the start task returns
  task automatic wait_ready();
    while (!ready) begin
      @(negedge CLK);
    end
  endtask

  task automatic run_random_vector(input int len, input bit with_stray);
    logic [DW-1:0] a;
    logic [EW-1:0] b;
    start_vector(len);
    for (int i = 0; i < len; i++) begin
      a = DW'($random(seed));
      b = EW'($random(seed));
      send_pair(a, b, i % 3, i % 4);
      if (with_stray) begin
        send_stray();
      end
      wait_result();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Result monitor, sampled mid-cycle
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST && (data_out_enable || ready)) begin
      // First strobe of a vector picks up its length
      if (cur_size < 0) begin
        assert (size_q.size() > 0) else begin
          protocol_errors++;
          $display("Output strobe at %0t with no vector started", $time);
        end
        cur_size = (size_q.size() > 0) ? size_q.pop_front() : 0;
        vec_results = 0;
      end
      if (data_out_enable) begin
        vec_results++;
        result_count++;
        assert (exp_q.size() > 0) else begin
          protocol_errors++;
          $display("Result at %0t that no element asked for", $time);
        end
        expected_value = (exp_q.size() > 0) ? exp_q.pop_front() : 'x;
        assert (data_out == expected_value) else begin
          value_errors++;
          $display("Fail %0t: element %0d of vector %0d gave %h, expected %h",
                   $time, vec_results - 1, ready_count, data_out, expected_value);
        end
        assert (ready == (vec_results == cur_size)) else begin
          protocol_errors++;
          $display("READY wrong at %0t on result %0d of %0d", $time, vec_results, cur_size);
        end
      end else begin
        // Lone READY only closes an empty vector
        assert (cur_size == 0) else begin
          protocol_errors++;
          $display("READY at %0t without a result in a vector of %0d", $time, cur_size);
        end
      end
      if (ready) begin
        ready_count++;
        cur_size = -1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    RST              = 1'b1;
    start            = 1'b0;
    size_in          = '0;
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
    data_a_in        = '0;
    data_b_in        = '0;
    repeat (RST_CYCLES) @(negedge CLK);
    RST = 1'b0;

    // Edge exponents and zero base
    start_vector(4);
    send_pair(16'h1234, 8'd0, 2, 0);
    wait_result();
    send_pair(16'hbeef, 8'd1, 2, 0);
    wait_result();
    send_pair(16'h0000, 8'd7, 0, 1);
    wait_result();
    send_pair(16'h0000, 8'd0, 1, 1);
    wait_result();

    // Random bases and exponents with wraparound
    run_random_vector(12, 1'b0);

    // Same operands in every strobe order, with and without gaps
    start_vector(6);
    for (int i = 0; i < 6; i++) begin
      send_pair(16'h0107, 8'd13, i % 3, (i < 3) ? 0 : 3);
      wait_result();
    end

    // Empty vector, then strobes while idle
    start_vector(0);
    wait_ready();
    send_stray();

    // Back-to-back vectors with ignored strobes in between
    run_random_vector(5, 1'b1);
    send_stray();
    run_random_vector(3, 1'b1);

    repeat (20) @(negedge CLK);
    assert (exp_q.size() == 0) else begin
      protocol_errors++;
      $display("%0d results never arrived", exp_q.size());
    end
    assert (ready_count == NUM_VECTORS && result_count == NUM_ELEMS) else begin
      protocol_errors++;
      $display("Saw %0d completions and %0d results, wanted %0d and %0d",
               ready_count, result_count, NUM_VECTORS, NUM_ELEMS);
    end
    $display("Checks done: %0d value errors, %0d protocol errors",
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
ntm_pkg.sv
ntm_scalar_multiplier.sv
ntm_scalar_exponentiator.sv
ntm_vector_exponentiator.sv
ntm_exponentiator_checker.sv
tb_ntm_vector_exponentiator.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the vector power unit testbench
# Verdict comes from a search of the simulation log

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -f filelist.f \
  --top-module tb_ntm_vector_exponentiator -o tb_sim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > "$LOG" 2>&1 || { echo "Simulator ended with an error, see $LOG"; exit 1; }

grep -qF "*** TEST FAILED ***" "$LOG" && { echo "FAIL, see $LOG"; exit 1; }
grep -qF "*** TEST PASSED ***" "$LOG" && echo "PASS" || { echo "FAIL, no verdict in $LOG"; exit 1; }
